// ==== sources.f ====
hdl/iq_pkg.sv
hdl/iq_ring_ptr.sv
hdl/iq_occupancy.sv
hdl/iq_storage.sv
hdl/instr_queue.sv
testbench/tb_clock.sv
testbench/instr_queue_tb.sv

// ==== testbench/instr_queue_tb.sv ====
/*
  Instruction queue testbench.
  Drives random writes, pops and flushes on both threads and checks
  stall, avail and read data against a FIFO model of each thread.
*/
module instr_queue_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import iq_pkg::*;

  localparam int RAND_CYCLES = 2000;
  localparam int WAIT_LIMIT  = 40;

  logic                   clk;
  logic                   rst;
  logic                   wr_en;
  logic                   wr_thread;
  logic [IQ_WR_LANES-1:0] wr_mask;
  iq_entry_t              wr_data [IQ_WR_LANES];
  logic                   rd_en;
  logic                   rd_thread;
  logic [IQ_RD_LANES-1:0] rd_mask;
  iq_flush_t              flush;
  logic                   stall;
  logic [IQ_RD_LANES-1:0] avail;
  iq_entry_t              rd_data [IQ_RD_LANES];

  logic [31:0] lfsr = 32'hd0ac2eb3;
  iq_entry_t   model_q [2][$];
  int          value_errors = 0;
  int          timeouts = 0;

  tb_clock clk_i (.clk(clk));

  instr_queue dut_i (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_thread (wr_thread),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_thread (rd_thread),
    .rd_mask   (rd_mask),
    .flush     (flush),
    .stall     (stall),
    .avail     (avail),
    .rd_data   (rd_data)
  );

  // the LFSR uses taps x^32 + x^22 + x^2 + x + 1 and steps once for every bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic iq_entry_t rand_entry();
    iq_entry_t   e;
    logic [31:0] b;
    for (int i = 0; i < $bits(iq_entry_t); i++) begin
      b = take_bits(1);
      e[i] = b[0];
    end
    return e;
  endfunction

  task automatic check_entry(input string name, input iq_entry_t exp, input iq_entry_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input logic [IQ_RD_LANES-1:0] exp,
                            input logic [IQ_RD_LANES-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_outputs();
    int                     wr_cnt;
    int                     rd_cnt;
    logic [IQ_RD_LANES-1:0] exp_avail;
    wr_cnt = model_q[wr_thread].size();
    rd_cnt = model_q[rd_thread].size();
    for (int i = 0; i < IQ_RD_LANES; i++) begin
      exp_avail[i] = rd_cnt > i;
    end
    check_bit("stall", wr_cnt > IQ_STALL_LIMIT, stall);
    check_mask("avail", exp_avail, avail);
    for (int i = 0; i < IQ_RD_LANES && i < rd_cnt; i++) begin
      check_entry($sformatf("rd_data[%0d]", i), model_q[rd_thread][i], rd_data[i]);
    end
  endtask

  // applies what the next rising edge does to the queue.
  task automatic update_model();
    logic wr_ok;
    wr_ok = wr_en && (wr_mask != '0) && (model_q[wr_thread].size() <= IQ_STALL_LIMIT) &&
            !(flush.valid && flush.thread == wr_thread);
    if (rd_en && !(flush.valid && flush.thread == rd_thread)) begin
      for (int i = 0; i < $countones(rd_mask); i++) begin
        void'(model_q[rd_thread].pop_front());
      end
    end
    if (wr_ok) begin
      for (int i = 0; i < IQ_WR_LANES; i++) begin
        if (wr_mask[i]) begin
          model_q[wr_thread].push_back(wr_data[i]);
        end
      end
    end
    if (flush.valid) begin
      model_q[flush.thread].delete();
    end
  endtask

  task automatic step_cycle();
    #1; // let the combinational outputs settle.
    check_outputs();
    update_model();
    @(negedge clk);
  endtask

  task automatic drive_idle();
    wr_en = 1'b0;
    wr_mask = '0;
    rd_en = 1'b0;
    rd_mask = '0;
    flush = '0;
  endtask

  task automatic drive_write(input logic thread, input int len);
    wr_en = len > 0;
    wr_thread = thread;
    wr_mask = IQ_WR_LANES'((1 << len) - 1);
    for (int i = 0; i < IQ_WR_LANES; i++) begin
      wr_data[i] = rand_entry();
    end
  endtask

  task automatic drive_read(input logic thread, input int len);
    rd_en = len > 0;
    rd_thread = thread;
    rd_mask = IQ_RD_LANES'((1 << len) - 1);
  endtask

  task automatic random_cycle(input bit fill);
    logic wt;
    logic rt;
    bit   wr_on;
    bit   rd_on;
    int   n;
    int   len;
    wt = take_bits(1);
    rt = take_bits(1);
    wr_on = fill ? (take_bits(2) != 0) : (take_bits(2) == 0); // writes dominate while filling.
    rd_on = fill ? take_bits(1) : (take_bits(2) != 0);
    drive_write(wt, wr_on ? 1 + int'(take_bits(2)) : 0);
    n = model_q[rt].size() < IQ_RD_LANES ? model_q[rt].size() : IQ_RD_LANES;
    len = (rd_on && n > 0) ? 1 + int'(take_bits(2)) % n : 0; // never past avail.
    drive_read(rt, len);
    flush.valid = take_bits(7) == 0;
    flush.thread = take_bits(1);
    step_cycle();
  endtask

  task automatic fill_until_stall(input logic thread);
    int waited;
    waited = 0;
    drive_idle();
    wr_thread = thread;
    rd_thread = thread;
    step_cycle();
    while (!stall) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout: stall never rose while filling thread %0d", thread);
        timeouts++;
        return;
      end
      drive_write(thread, IQ_WR_LANES);
      step_cycle();
      waited++;
    end
    drive_write(thread, IQ_WR_LANES); // dropped by the stall.
    step_cycle();
    drive_idle();
    flush = '{valid: 1'b1, thread: thread};
    step_cycle();
    drive_idle();
    step_cycle();
  endtask

  task automatic drain_all();
    int   waited;
    logic t;
    int   n;
    waited = 0;
    while (model_q[0].size() != 0 || model_q[1].size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout: queue did not drain");
        timeouts++;
        return;
      end
      t = (model_q[0].size() != 0) ? 1'b0 : 1'b1;
      n = model_q[t].size() < IQ_RD_LANES ? model_q[t].size() : IQ_RD_LANES;
      drive_idle();
      drive_read(t, n);
      step_cycle();
      waited++;
    end
    drive_idle();
    rd_thread = 1'b0;
    step_cycle();
    rd_thread = 1'b1;
    step_cycle();
  endtask

  initial begin
    rst = 1'b1;
    wr_thread = 1'b0;
    rd_thread = 1'b0;
    drive_idle();
    for (int i = 0; i < IQ_WR_LANES; i++) begin
      wr_data[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_mask("avail after reset", '0, avail);
    check_bit("stall after reset", 1'b0, stall);
    @(negedge clk);
    fill_until_stall(1'b0);
    if (timeouts == 0) begin
      for (int c = 0; c < RAND_CYCLES; c++) begin
        random_cycle(((c / 64) % 2) == 0);
      end
      drain_all();
    end
    $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clock.sv ====
/*
  Testbench clock generator.
  Free-running clock with an 8 ns period.
*/
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  always #4 clk = ~clk;

endmodule

// ==== hdl/instr_queue.sv ====
/*
  Two-thread instruction queue.
  Accepts up to four instructions per cycle into the write thread and
  presents up to three from the head of the read thread. A flush
  empties one thread; stall warns the front end before the queue fills.
*/
module instr_queue (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_en,
  input  logic                           wr_thread,
  input  logic [iq_pkg::IQ_WR_LANES-1:0] wr_mask,
  input  iq_pkg::iq_entry_t              wr_data [iq_pkg::IQ_WR_LANES],
  input  logic                           rd_en,
  input  logic                           rd_thread,
  input  logic [iq_pkg::IQ_RD_LANES-1:0] rd_mask,
  input  iq_pkg::iq_flush_t              flush,
  output logic                           stall,
  output logic [iq_pkg::IQ_RD_LANES-1:0] avail,
  output iq_pkg::iq_entry_t              rd_data [iq_pkg::IQ_RD_LANES]
);
  import iq_pkg::*;

  logic    wr_flushed;
  logic    rd_flushed;
  logic    wr_go;
  logic    rd_go;
  iq_ptr_t wr_ptr;
  iq_ptr_t rd_ptr;

  assign wr_flushed = flush.valid && (flush.thread == wr_thread);
  assign rd_flushed = flush.valid && (flush.thread == rd_thread);

  // a write during stall is dropped and the producer retries.
  assign wr_go = wr_en && (wr_mask != '0) && !stall && !wr_flushed;
  assign rd_go = rd_en && (rd_mask != '0) && !rd_flushed;

  iq_ring_ptr #(
    .LANES (IQ_WR_LANES)
  ) wr_ptr_i (
    .clk     (clk),
    .rst     (rst),
    .advance (wr_go),
    .thread  (wr_thread),
    .mask    (wr_mask),
    .flush   (flush),
    .ptr     (wr_ptr)
  );

  iq_ring_ptr #(
    .LANES (IQ_RD_LANES)
  ) rd_ptr_i (
    .clk     (clk),
    .rst     (rst),
    .advance (rd_go),
    .thread  (rd_thread),
    .mask    (rd_mask),
    .flush   (flush),
    .ptr     (rd_ptr)
  );

  iq_occupancy occ_i (
    .clk       (clk),
    .rst       (rst),
    .wr_go     (wr_go),
    .wr_thread (wr_thread),
    .wr_mask   (wr_mask),
    .rd_go     (rd_go),
    .rd_thread (rd_thread),
    .rd_mask   (rd_mask),
    .flush     (flush),
    .stall     (stall),
    .avail     (avail)
  );

  iq_storage store_i (
    .clk       (clk),
    .wr_go     (wr_go),
    .wr_thread (wr_thread),
    .wr_ptr    (wr_ptr),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data),
    .rd_thread (rd_thread),
    .rd_ptr    (rd_ptr),
    .rd_data   (rd_data)
  );

  // lane masks fill from lane 0 upward with no gaps.
  a_wr_mask_thermo: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> ((wr_mask & (wr_mask + 1'b1)) == '0));

  a_rd_mask_thermo: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> ((rd_mask & (rd_mask + 1'b1)) == '0));

endmodule

// ==== hdl/iq_storage.sv ====
/*
  Instruction queue entry store.
  Two per-thread arrays of entries. Up to four lanes are written at
  consecutive slots from the write pointer; three consecutive slots
  from the read pointer are read combinationally.
*/
module iq_storage (
  input  logic                           clk,
  input  logic                           wr_go,
  input  logic                           wr_thread,
  input  iq_pkg::iq_ptr_t                wr_ptr,
  input  logic [iq_pkg::IQ_WR_LANES-1:0] wr_mask,
  input  iq_pkg::iq_entry_t              wr_data [iq_pkg::IQ_WR_LANES],
  input  logic                           rd_thread,
  input  iq_pkg::iq_ptr_t                rd_ptr,
  output iq_pkg::iq_entry_t              rd_data [iq_pkg::IQ_RD_LANES]
);
  import iq_pkg::*;

  iq_entry_t mem [2][IQ_DEPTH];
  iq_ptr_t   wr_addr [IQ_WR_LANES];
  iq_ptr_t   rd_addr [IQ_RD_LANES];

  // lane offsets wrap modulo the depth.
  always_comb begin
    for (int i = 0; i < IQ_WR_LANES; i++) begin
      wr_addr[i] = wr_ptr + iq_ptr_t'(i);
    end
    for (int i = 0; i < IQ_RD_LANES; i++) begin
      rd_addr[i] = rd_ptr + iq_ptr_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      for (int i = 0; i < IQ_WR_LANES; i++) begin
        if (wr_mask[i]) begin
          mem[wr_thread][wr_addr[i]] <= wr_data[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < IQ_RD_LANES; i++) begin
      rd_data[i] = mem[rd_thread][rd_addr[i]]; // valid only where the lane is available.
    end
  end

endmodule

// ==== hdl/iq_occupancy.sv ====
/*
  Queue occupancy tracking.
  Keeps a busy count per thread, raises the front-end stall for the
  write thread and reports per-lane availability for the read thread.
*/
module iq_occupancy (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_go,
  input  logic                           wr_thread,
  input  logic [iq_pkg::IQ_WR_LANES-1:0] wr_mask,
  input  logic                           rd_go,
  input  logic                           rd_thread,
  input  logic [iq_pkg::IQ_RD_LANES-1:0] rd_mask,
  input  iq_pkg::iq_flush_t              flush,
  output logic                           stall,
  output logic [iq_pkg::IQ_RD_LANES-1:0] avail
);
  import iq_pkg::*;

  iq_cnt_t cnt_q [2];
  iq_cnt_t cnt_d [2];
  iq_cnt_t wr_num;
  iq_cnt_t rd_num;

  assign wr_num = lane_count(wr_mask);
  assign rd_num = lane_count(IQ_WR_LANES'(rd_mask));

  // writes and pops of the same thread combine in one update.
  always_comb begin
    for (int t = 0; t < 2; t++) begin
      cnt_d[t] = cnt_q[t];
      if (wr_go && wr_thread == 1'(t)) begin
        cnt_d[t] = cnt_d[t] + wr_num;
      end
      if (rd_go && rd_thread == 1'(t)) begin
        cnt_d[t] = cnt_d[t] - rd_num;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q[0] <= '0;
      cnt_q[1] <= '0;
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (flush.valid && flush.thread == 1'(t)) begin
          cnt_q[t] <= '0; // flush wins over traffic to the same thread.
        end else begin
          cnt_q[t] <= cnt_d[t];
        end
      end
    end
  end

  assign stall = cnt_q[wr_thread] > iq_cnt_t'(IQ_STALL_LIMIT);

  always_comb begin
    for (int i = 0; i < IQ_RD_LANES; i++) begin
      avail[i] = cnt_q[rd_thread] > iq_cnt_t'(i);
    end
  end

  a_pop_within_avail: assert property (@(posedge clk) disable iff (rst)
    rd_go |-> ((rd_mask & ~avail) == '0));

  // the stall threshold must keep both counts within the store.
  a_count_bounded: assert property (@(posedge clk) disable iff (rst)
    (cnt_q[0] <= iq_cnt_t'(IQ_DEPTH)) && (cnt_q[1] <= iq_cnt_t'(IQ_DEPTH)));

endmodule

// ==== hdl/iq_ring_ptr.sv ====
/*
  Per-thread ring pointers.
  One pointer per thread, advanced by the number of lanes used and
  cleared by a flush of that thread. The selected thread's pointer is
  presented combinationally.
*/
module iq_ring_ptr #(
  parameter int LANES = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               advance,
  input  logic               thread,
  input  logic [LANES-1:0]   mask,
  input  iq_pkg::iq_flush_t  flush,
  output iq_pkg::iq_ptr_t    ptr
);
  import iq_pkg::*;

  iq_ptr_t ptr_q [2];
  iq_ptr_t step;

  assign step = iq_ptr_t'(lane_count(IQ_WR_LANES'(mask))); // at most four lanes.

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q[0] <= '0;
      ptr_q[1] <= '0;
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (flush.valid && flush.thread == 1'(t)) begin
          ptr_q[t] <= '0;
        end else if (advance && thread == 1'(t)) begin
          ptr_q[t] <= ptr_q[t] + step; // wraps at the power-of-two depth.
        end
      end
    end
  end

  assign ptr = ptr_q[thread];

endmodule

// ==== hdl/iq_pkg.sv ====
/*
  Instruction queue definitions.
  Sizes, entry and flush structs, pointer and count types, and the lane
  count helper shared by the two-thread instruction queue.
*/
package iq_pkg;

  localparam int IQ_INSTR_W     = 80;
  localparam int IQ_INFO_W      = 8;
  localparam int IQ_WR_LANES    = 4;
  localparam int IQ_RD_LANES    = 3;
  localparam int IQ_DEPTH       = 16;
  localparam int IQ_PTR_W       = 4;
  localparam int IQ_CNT_W       = 5;
  localparam int IQ_STALL_LIMIT = IQ_DEPTH - IQ_WR_LANES; // room for one more full group.

  typedef struct packed {
    logic [IQ_INSTR_W-1:0] instr;
    logic [IQ_INFO_W-1:0]  info;
  } iq_entry_t;

  typedef struct packed {
    logic valid;
    logic thread;
  } iq_flush_t;

  typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
  typedef logic [IQ_CNT_W-1:0] iq_cnt_t;

  // number of lanes set in a mask; narrower masks are zero extended.
  function automatic iq_cnt_t lane_count(input logic [IQ_WR_LANES-1:0] mask);
    iq_cnt_t n;
    n = '0;
    for (int i = 0; i < IQ_WR_LANES; i++) begin
      n = n + iq_cnt_t'(mask[i]);
    end
    return n;
  endfunction

endpackage
